// File: flist.f
design/fsrc_pkg.sv
design/fsrc_apb_regs.sv
design/fsrc_accum_gate.sv
design/fsrc_out_stage.sv
design/fsrc_tx.sv
verif/fsrc_checker.sv
verif/tb_fsrc_tx.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run, the result is read from the simulation output
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/100ps --top-module tb_fsrc_tx -f flist.f -o sim_fsrc \
  && ./obj_dir/sim_fsrc | tee /dev/stderr | grep "TEST PASSED" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: verif/tb_fsrc_tx.sv
`timescale 1ns/100ps

module tb_fsrc_tx import fsrc_pkg::*; ();

  logic                 clk;
  logic                 arst_n;
  logic                 start;
  logic                 data_in_valid;
  lane_vec_t            data_in;
  logic                 data_in_ready;
  logic                 data_out_valid;
  lane_vec_t            data_out;
  apb_req_t             apb_req;
  apb_rsp_t             apb_rsp;
  logic [NUM_LANES-1:0] lane_mask;
  logic                 gap_en;
  int                   timeouts;

  fsrc_tx uut (
    .clk            (clk),
    .arst_n         (arst_n),
    .start          (start),
    .data_in_valid  (data_in_valid),
    .data_in        (data_in),
    .data_in_ready  (data_in_ready),
    .data_out_valid (data_out_valid),
    .data_out       (data_out),
    .apb_req        (apb_req),
    .apb_rsp        (apb_rsp)
  );

  fsrc_checker chk (
    .clk            (clk),
    .arst_n         (arst_n),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .data_in        (data_in),
    .data_out_valid (data_out_valid),
    .data_out       (data_out),
    .lane_mask      (lane_mask),
    .gap_en         (gap_en)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // Fresh random lanes every cycle
  always @(negedge clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      data_in[i] = SAMPLE_WIDTH'($urandom);
    end
  end

  // Number of carries in the first k steps when A is added to L each step
  function automatic int holes_upto(input logic [31:0] l, input logic [31:0] a, input int k);
    logic [63:0] sum;
    sum = {32'd0, l} + {32'd0, a} * 64'(k);
    return int'(sum[63:32]);
  endfunction

  // ********************************************************************
  // APB master and wait helpers
  // ********************************************************************

  task automatic apb_access(input logic wr, input logic [APB_ADDR_WIDTH-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int n;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    n = 0;
    #2;
    while (!apb_rsp.pready && n < 16) begin
      @(negedge clk);
      #2;
      n++;
    end
    if (!apb_rsp.pready) begin
      $display("Timeout: no pready for the APB access to address %h", addr);
      timeouts++;
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic reg_write(input logic [APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, data, rd, err);
    chk.check_word("pslverr on write", 32'd0, {31'd0, err});
  endtask

  task automatic reg_read(input logic [APB_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, 32'd0, data, err);
    chk.check_word("pslverr on read", 32'd0, {31'd0, err});
  endtask

  task automatic wait_ready_level(input logic level, input string what);
    int n;
    n = 0;
    while (data_in_ready !== level && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (data_in_ready !== level) begin
      $display("Timeout: data_in_ready did not go to %b after %s", level, what);
      timeouts++;
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (chk.pending() != 0 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (chk.pending() != 0) begin
      $display("Timeout: accepted samples never came out of the converter");
      timeouts++;
    end
  endtask

  // Start, stream with valid held high, then stop and let the pipeline empty
  task automatic run_stream(input int cycles);
    data_in_valid = 1'b1;
    reg_write(REG_COMMAND, 32'h1);
    repeat (cycles) @(negedge clk);
    data_in_valid = 1'b0;
    reg_write(REG_COMMAND, 32'h2);
    wait_drained();
  endtask

  // ********************************************************************
  // Test sequence
  // ********************************************************************

  initial begin
    logic [31:0] rd;
    logic        err;
    logic [31:0] l_val;
    logic [31:0] a_val;
    int          n0;
    int          h;
    int          h_prev;
    int          gap;
    int          accepted;
    int          errors;
    void'($urandom(71422));
    arst_n        = 1'b0;
    start         = 1'b0;
    data_in_valid = 1'b0;
    data_in       = '0;
    apb_req       = '0;
    lane_mask     = '0;
    gap_en        = 1'b0;
    timeouts      = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    chk.set_test("registers");
    chk.check_word("ready after reset", 32'd0, {31'd0, data_in_ready});
    chk.check_word("valid after reset", 32'd0, {31'd0, data_out_valid});
    reg_read(REG_VERSION, rd);
    chk.check_word("version", CORE_VERSION, rd);
    reg_read(REG_MAGIC, rd);
    chk.check_word("magic", CORE_MAGIC, rd);
    reg_read(REG_CONTROL, rd);
    chk.check_word("control after reset", 32'd0, rd);
    apb_access(1'b0, 12'h100, 32'd0, rd, err);
    chk.check_word("pslverr unknown read", 32'd1, {31'd0, err});
    chk.check_word("data unknown read", 32'd0, rd);
    apb_access(1'b1, 12'h0FC, 32'hFFFF_FFFF, rd, err);
    chk.check_word("pslverr unknown write", 32'd1, {31'd0, err});
    reg_read(REG_CONTROL, rd);
    chk.check_word("control after unknown write", 32'd0, rd);

    chk.set_test("passthrough");
    reg_write(REG_CONTROL, 32'h1);
    reg_write(REG_LANE_MASK, 32'hF);
    lane_mask = '1;
    reg_write(REG_ACCUM_ADD, 32'd0);
    reg_write(REG_ACCUM_SET, 32'd0);
    n0 = chk.out_total;
    run_stream(40);
    reg_read(REG_OUT_COUNT, rd);
    chk.check_word("out count", 32'(chk.out_total - n0), rd);

    // Step stays below 3/4 of the range so the gaps stay short
    chk.set_test("hole insertion");
    l_val = $urandom;
    a_val = $urandom % 32'hC000_0000;
    reg_write(REG_ACCUM_ADD, a_val);
    reg_write(REG_ACCUM_SET, l_val);
    h_prev   = 0;
    gap      = 0;
    accepted = 0;
    for (int k = 1; k <= 300; k++) begin
      h = holes_upto(l_val, a_val, k);
      if (h == h_prev) begin
        if (accepted > 0) begin
          chk.expect_gap(gap);
        end
        accepted++;
        gap = 0;
      end else begin
        gap++;
      end
      h_prev = h;
    end
    gap_en = 1'b1;
    run_stream(100);
    gap_en = 1'b0;
    chk.clear_gaps();

    chk.set_test("lane mask");
    reg_write(REG_ACCUM_ADD, 32'd0);
    reg_write(REG_ACCUM_SET, 32'd0);
    lane_mask = NUM_LANES'($urandom);
    reg_write(REG_LANE_MASK, 32'(lane_mask));
    n0 = chk.out_total;
    run_stream(20);
    reg_read(REG_OUT_COUNT, rd);
    chk.check_word("out count after restart", 32'(chk.out_total - n0), rd);

    chk.set_test("triggers");
    reg_write(REG_LANE_MASK, 32'hF);
    lane_mask     = '1;
    data_in_valid = 1'b1;
    start         = 1'b1;
    @(negedge clk);
    start = 1'b0;
    repeat (8) begin
      @(negedge clk);
      chk.check_word("ready without trigger", 32'd0, {31'd0, data_in_ready});
    end
    reg_write(REG_CONTROL, 32'h3);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    wait_ready_level(1'b1, "the start pin");
    repeat (10) @(negedge clk);
    reg_write(REG_CONTROL, 32'h0);
    wait_ready_level(1'b0, "clearing enable");
    repeat (8) begin
      @(negedge clk);
      chk.check_word("ready after disable", 32'd0, {31'd0, data_in_ready});
    end
    data_in_valid = 1'b0;
    wait_drained();

    errors = chk.data_errs + chk.gap_errs + chk.reg_errs + timeouts;
    $display("Errors: data %0d, hole gap %0d, register %0d, timeout %0d",
             chk.data_errs, chk.gap_errs, chk.reg_errs, timeouts);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verif/fsrc_checker.sv
`timescale 1ns/100ps

module fsrc_checker import fsrc_pkg::*; (
  input logic                 clk,
  input logic                 arst_n,
  input logic                 data_in_valid,
  input logic                 data_in_ready,
  input lane_vec_t            data_in,
  input logic                 data_out_valid,
  input lane_vec_t            data_out,
  input logic [NUM_LANES-1:0] lane_mask,
  input logic                 gap_en
);

  typedef struct packed {
    lane_vec_t   data;
    int unsigned cyc;
  } xfer_t;

  xfer_t       xfers[$];
  int          gaps[$];
  string       test_name = "reset";
  int unsigned cycle = 0;
  int          idle = -1;
  int          out_total = 0;
  int          data_errs = 0;
  int          gap_errs = 0;
  int          reg_errs = 0;

  task automatic set_test(input string name);
    test_name = name;
  endtask

  task automatic check_word(input string what, input logic [31:0] exp_val,
                            input logic [31:0] act);
    if (exp_val !== act) begin
      $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp_val, act);
      reg_errs++;
    end
  endtask

  task automatic expect_gap(input int gap);
    gaps.push_back(gap);
  endtask

  task automatic clear_gaps();
    gaps.delete();
  endtask

  function automatic int pending();
    return xfers.size();
  endfunction

  // ********************************************************************
  // Each output pairs with the oldest accepted input
  // ********************************************************************

  always @(posedge clk) begin
    xfer_t     x;
    lane_vec_t exp_data;
    int        exp_gap;
    cycle++;
    if (arst_n && data_out_valid) begin
      if (xfers.size() == 0) begin
        $display("Output in %s at cycle %0d without an accepted input", test_name, cycle);
        data_errs++;
      end else begin
        x = xfers.pop_front();
        for (int i = 0; i < NUM_LANES; i++) begin
          exp_data[i] = lane_mask[i] ? x.data[i] : '0;
        end
        if (data_out !== exp_data) begin
          $display("CHECK FAILED %s data_out: expected %h actual %h",
                   test_name, exp_data, data_out);
          data_errs++;
        end
        if (cycle != x.cyc + 2) begin
          $display("CHECK FAILED %s latency: expected 2 actual %0d", test_name, cycle - x.cyc);
          data_errs++;
        end
      end
      // Idle cycles since the previous output must match the expected holes
      if (idle >= 0 && gaps.size() > 0) begin
        exp_gap = gaps.pop_front();
        if (exp_gap != idle) begin
          $display("CHECK FAILED %s hole gap: expected %0d actual %0d", test_name, exp_gap, idle);
          gap_errs++;
        end
      end
      out_total++;
      idle = 0;
    end else if (idle >= 0) begin
      idle++;
    end
    if (!gap_en) begin
      idle = -1;
    end
    if (arst_n && data_in_valid && data_in_ready) begin
      x.data = data_in;
      x.cyc  = cycle;
      xfers.push_back(x);
    end
  end

endmodule

// File: design/fsrc_tx.sv
`timescale 1ns/100ps

module fsrc_tx import fsrc_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      start,

  input  logic      data_in_valid,
  input  lane_vec_t data_in,
  output logic      data_in_ready,

  output logic      data_out_valid,
  output lane_vec_t data_out,

  input  apb_req_t  apb_req,
  output apb_rsp_t  apb_rsp
);

  fsrc_cfg_t   cfg;
  fsrc_cmd_t   cmd;
  logic        acc_valid;
  logic        out_clear;
  lane_vec_t   acc_data;
  logic [31:0] out_count;

  // ********************************************************************
  // Register block
  // ********************************************************************

  fsrc_apb_regs i_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .out_count (out_count),
    .cfg       (cfg),
    .cmd       (cmd)
  );

  // ********************************************************************
  // Accumulator and input gating
  // ********************************************************************

  fsrc_accum_gate i_accum_gate (
    .clk           (clk),
    .arst_n        (arst_n),
    .start         (start),
    .data_in_valid (data_in_valid),
    .data_in       (data_in),
    .cfg           (cfg),
    .cmd           (cmd),
    .data_in_ready (data_in_ready),
    .acc_valid     (acc_valid),
    .out_clear     (out_clear),
    .acc_data      (acc_data)
  );

  // ********************************************************************
  // Output side
  // ********************************************************************

  fsrc_out_stage i_out_stage (
    .clk            (clk),
    .arst_n         (arst_n),
    .acc_valid      (acc_valid),
    .out_clear      (out_clear),
    .acc_data       (acc_data),
    .lane_mask      (cfg.lane_mask),
    .data_out_valid (data_out_valid),
    .data_out       (data_out),
    .out_count      (out_count)
  );

endmodule

// File: design/fsrc_out_stage.sv
`timescale 1ns/100ps

module fsrc_out_stage import fsrc_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 acc_valid,
  input  logic                 out_clear,
  input  lane_vec_t            acc_data,
  input  logic [NUM_LANES-1:0] lane_mask,
  output logic                 data_out_valid,
  output lane_vec_t            data_out,
  output logic [31:0]          out_count
);

  lane_vec_t masked_data;

  // Lanes with a cleared mask bit are forced to zero
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      masked_data[i] = lane_mask[i] ? acc_data[i] : '0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_out_valid <= 1'b0;
      data_out       <= '0;
    end else begin
      data_out_valid <= acc_valid;
      if (acc_valid) begin
        data_out <= masked_data;
      end
    end
  end

  // ********************************************************************
  // Emitted output counter
  // ********************************************************************

  // A sample emitted on the clear cycle is the first one of the new run
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_count <= '0;
    end else if (out_clear) begin
      out_count <= {31'd0, acc_valid};
    end else if (acc_valid) begin
      out_count <= out_count + 32'd1;
    end
  end

endmodule

// File: design/fsrc_accum_gate.sv
`timescale 1ns/100ps

module fsrc_accum_gate import fsrc_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      start,
  input  logic      data_in_valid,
  input  lane_vec_t data_in,
  input  fsrc_cfg_t cfg,
  input  fsrc_cmd_t cmd,
  output logic      data_in_ready,
  output logic      acc_valid,
  output logic      out_clear,
  output lane_vec_t acc_data
);

  logic                   running;
  logic                   start_evt;
  logic                   start_ok;
  logic                   hole;
  logic                   accept;
  logic [ACCUM_WIDTH-1:0] accum;
  logic [ACCUM_WIDTH:0]   accum_sum;

  // ********************************************************************
  // Run control
  // ********************************************************************

  // The start pin only counts when the external trigger is enabled
  assign start_evt = cmd.start | (start & cfg.ext_trig_en);
  assign start_ok  = start_evt & cfg.enable & ~cmd.stop;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      running <= 1'b0;
    end else if (cmd.stop || !cfg.enable) begin
      running <= 1'b0;
    end else if (start_evt) begin
      running <= 1'b1;
    end
  end

  // Clears the output counter at the start of every run
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_clear <= 1'b0;
    end else begin
      out_clear <= start_ok;
    end
  end

  // ********************************************************************
  // Phase accumulator
  // ********************************************************************

  // Extra top bit is the carry that marks a hole
  assign accum_sum = {1'b0, accum} + {1'b0, cfg.accum_add};
  assign hole      = accum_sum[ACCUM_WIDTH];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      accum <= '0;
    end else if (cmd.accum_load) begin
      accum <= cmd.accum_set_val;
    end else if (running) begin
      accum <= accum_sum[ACCUM_WIDTH-1:0];
    end
  end

  // ********************************************************************
  // Input gating
  // ********************************************************************

  // An underflow cycle still moves the phase on but yields no output
  assign data_in_ready = running & ~hole;
  assign accept        = data_in_valid & data_in_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      acc_data <= data_in;
    end
  end

endmodule

// File: design/fsrc_apb_regs.sv
`timescale 1ns/100ps

module fsrc_apb_regs import fsrc_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  apb_req_t    apb_req,
  output apb_rsp_t    apb_rsp,
  input  logic [31:0] out_count,
  output fsrc_cfg_t   cfg,
  output fsrc_cmd_t   cmd
);

  logic        access;
  logic        wr_en;
  logic        rd_en;
  logic        addr_hit;
  logic [31:0] rd_data;

  // ********************************************************************
  // Bus decode
  // ********************************************************************

  // The access phase is the only cycle that does anything because pready is tied high
  assign access = apb_req.psel & apb_req.penable;
  assign wr_en  = access & apb_req.pwrite;
  assign rd_en  = access & ~apb_req.pwrite;

  always_comb begin
    addr_hit = 1'b1;
    rd_data  = '0;
    case (apb_req.paddr)
      REG_VERSION: begin
        rd_data = CORE_VERSION;
      end
      REG_MAGIC: begin
        rd_data = CORE_MAGIC;
      end
      REG_CONTROL: begin
        rd_data = {30'd0, cfg.ext_trig_en, cfg.enable};
      end
      REG_COMMAND: begin
        // Write-only register that reads as zero
        rd_data = '0;
      end
      REG_ACCUM_ADD: begin
        rd_data = cfg.accum_add;
      end
      REG_ACCUM_SET: begin
        rd_data = cmd.accum_set_val;
      end
      REG_LANE_MASK: begin
        rd_data = {{(32-NUM_LANES){1'b0}}, cfg.lane_mask};
      end
      REG_OUT_COUNT: begin
        rd_data = out_count;
      end
      default: begin
        addr_hit = 1'b0;
        rd_data  = '0;
      end
    endcase
  end

  assign apb_rsp.prdata  = rd_en ? rd_data : '0;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access & ~addr_hit;

  // ********************************************************************
  // Configuration registers
  // ********************************************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cfg.enable      <= 1'b0;
      cfg.ext_trig_en <= 1'b0;
      cfg.accum_add   <= '0;
      cfg.lane_mask   <= '0;
    end else if (wr_en) begin
      case (apb_req.paddr)
        REG_CONTROL: begin
          cfg.enable      <= apb_req.pwdata[0];
          cfg.ext_trig_en <= apb_req.pwdata[1];
        end
        REG_ACCUM_ADD: begin
          cfg.accum_add <= apb_req.pwdata[ACCUM_WIDTH-1:0];
        end
        REG_LANE_MASK: begin
          cfg.lane_mask <= apb_req.pwdata[NUM_LANES-1:0];
        end
        default: begin
          cfg <= cfg;
        end
      endcase
    end
  end

  // ********************************************************************
  // Command pulses
  // ********************************************************************

  // Pulses are high for the one cycle that follows the write edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cmd.start      <= 1'b0;
      cmd.stop       <= 1'b0;
      cmd.accum_load <= 1'b0;
    end else begin
      cmd.start      <= wr_en && (apb_req.paddr == REG_COMMAND) && apb_req.pwdata[0];
      cmd.stop       <= wr_en && (apb_req.paddr == REG_COMMAND) && apb_req.pwdata[1];
      cmd.accum_load <= wr_en && (apb_req.paddr == REG_ACCUM_SET);
    end
  end

  // The set value is held so it can be read back
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cmd.accum_set_val <= '0;
    end else if (wr_en && (apb_req.paddr == REG_ACCUM_SET)) begin
      cmd.accum_set_val <= apb_req.pwdata[ACCUM_WIDTH-1:0];
    end
  end

endmodule

// File: design/fsrc_pkg.sv
package fsrc_pkg;

  // ********************************************************************
  // Sizes
  // ********************************************************************

  localparam int NUM_LANES      = 4;
  localparam int SAMPLE_WIDTH   = 16;
  localparam int ACCUM_WIDTH    = 32;
  localparam int APB_ADDR_WIDTH = 12;

  // Major 0, minor 1, patch 0
  localparam logic [31:0] CORE_VERSION = {16'h0000, 8'h01, 8'h00};
  // ASCII "FSRC"
  localparam logic [31:0] CORE_MAGIC   = 32'h4653_5243;

  // ********************************************************************
  // Register map
  // ********************************************************************

  localparam logic [APB_ADDR_WIDTH-1:0] REG_VERSION   = 12'h000;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_MAGIC     = 12'h004;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_CONTROL   = 12'h010;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_COMMAND   = 12'h014;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_ACCUM_ADD = 12'h018;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_ACCUM_SET = 12'h01C;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_LANE_MASK = 12'h020;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_OUT_COUNT = 12'h024;

  // Lane 0 sits in the low bits
  typedef logic [NUM_LANES-1:0][SAMPLE_WIDTH-1:0] lane_vec_t;

  typedef struct packed {
    logic                   enable;
    logic                   ext_trig_en;
    logic [ACCUM_WIDTH-1:0] accum_add;
    logic [NUM_LANES-1:0]   lane_mask;
  } fsrc_cfg_t;

  // Single cycle pulses plus the value loaded on accum_load
  typedef struct packed {
    logic                   start;
    logic                   stop;
    logic                   accum_load;
    logic [ACCUM_WIDTH-1:0] accum_set_val;
  } fsrc_cmd_t;

  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [31:0]               pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage
